// File: common/router_consts.svh
`ifndef ROUTER_CONSTS_SVH
`define ROUTER_CONSTS_SVH

// framer address width in words
`define ROUTER_BUF_SIZE 9

// header lines held by the inspector
// padded ethernet, ip, udp and the first vrt line
`define ROUTER_HDR_LINES 12

// first buffered line sent on for a dsp packet
`define ROUTER_DSP_OFFSET 11

// ethertype line, compared in data bits 15:0
`define ROUTER_ETHTYPE_IDX 3
`define ROUTER_ETHTYPE_IPV4 16'h0800

// ip protocol line, compared in data bits 23:16
`define ROUTER_PROTO_IDX 6
`define ROUTER_PROTO_UDP 8'h11

// udp destination port line, compared in data bits 15:0
`define ROUTER_PORT_IDX 9
`define ROUTER_PORT_DSP 16'd49153

// upper half of the frame header word
`define ROUTER_FRM_HDR_TAG 16'h0001

`endif

// File: common/router_pkg.sv
package router_pkg;

    // one line of a stream, flags on top of the data
    typedef struct packed {
        logic [1:0]  occ;
        logic        eof;
        logic        sof;
        logic [31:0] data;
    } stream_word_t;

    // dsp framer states
    typedef enum logic [1:0] {
        frm_wait_sof   = 2'd0,
        frm_wait_eof   = 2'd1,
        frm_write_hdr  = 2'd2,
        frm_write_body = 2'd3
    } frm_state_e;

    // communication inspector states
    typedef enum logic [1:0] {
        insp_read_first = 2'd0,
        insp_read_hdr   = 2'd1,
        insp_replay     = 2'd2,
        insp_live       = 2'd3
    } insp_state_e;

    // where the inspector sends the current packet
    typedef enum logic {
        dest_dsp  = 1'b0,
        dest_host = 1'b1
    } insp_dest_e;

    // combiner input that owns the output
    typedef enum logic {
        src_frm  = 1'b0,
        src_host = 1'b1
    } comb_src_e;

endpackage

// File: design/packet_combiner.sv
`timescale 1ns/1ps

module packet_combiner (
    input  logic                     stream_clk_i,
    input  logic                     stream_rst_i,
    input  router_pkg::stream_word_t frm_data_i,
    input  logic                     frm_valid_i,
    output logic                     frm_ready_o,
    input  router_pkg::stream_word_t host_data_i,
    input  logic                     host_valid_i,
    output logic                     host_ready_o,
    output router_pkg::stream_word_t out_data_o,
    output logic                     out_valid_o,
    input  logic                     out_ready_i
);
    import router_pkg::*;

    logic      locked;
    comb_src_e lock_src;
    comb_src_e last_src;
    comb_src_e pick;
    comb_src_e sel;
    logic      out_xfer;

    ////////////////////////////////////////////////////////////////////////////
    // arbitration at packet start
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (frm_valid_i && host_valid_i) begin
            // both pending, take turns
            pick = (last_src == src_host) ? src_frm : src_host;
        end else if (host_valid_i) begin
            pick = src_host;
        end else begin
            pick = src_frm;
        end
    end

    assign sel = locked ? lock_src : pick;

    // same cycle forwarding from the granted source
    assign out_data_o   = (sel == src_frm) ? frm_data_i : host_data_i;
    assign out_valid_o  = (sel == src_frm) ? frm_valid_i : host_valid_i;
    assign frm_ready_o  = out_ready_i && (sel == src_frm);
    assign host_ready_o = out_ready_i && (sel == src_host);

    assign out_xfer = out_valid_o && out_ready_i;

    ////////////////////////////////////////////////////////////////////////////
    // packet lock
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge stream_clk_i) begin
        if (stream_rst_i) begin
            locked   <= 1'b0;
            lock_src <= src_frm;
            // framer goes first after reset
            last_src <= src_host;
        end else if (out_xfer) begin
            // grant held until the eof word leaves
            locked   <= !out_data_o.eof;
            lock_src <= sel;
            last_src <= sel;
        end
    end

endmodule

// File: design/packet_router.sv
`timescale 1ns/1ps

module packet_router (
    input  logic                     stream_clk,
    input  logic                     stream_rst,
    input  router_pkg::stream_word_t dsp_inp_data_i,
    input  logic                     dsp_inp_valid_i,
    output logic                     dsp_inp_ready_o,
    input  router_pkg::stream_word_t com_inp_data_i,
    input  logic                     com_inp_valid_i,
    output logic                     com_inp_ready_o,
    output router_pkg::stream_word_t com_out_data_o,
    output logic                     com_out_valid_o,
    input  logic                     com_out_ready_i,
    output router_pkg::stream_word_t dsp_out_data_o,
    output logic                     dsp_out_valid_o,
    input  logic                     dsp_out_ready_i
);
    import router_pkg::*;

    // framed dsp packets toward the combiner
    stream_word_t frm_data;
    logic         frm_valid;
    logic         frm_ready;

    // host traffic from the inspector
    stream_word_t host_data;
    logic         host_valid;
    logic         host_ready;

    dsp_framer u_dsp_framer (
        .stream_clk_i (stream_clk),
        .stream_rst_i (stream_rst),
        .dsp_data_i   (dsp_inp_data_i),
        .dsp_valid_i  (dsp_inp_valid_i),
        .dsp_ready_o  (dsp_inp_ready_o),
        .frm_data_o   (frm_data),
        .frm_valid_o  (frm_valid),
        .frm_ready_i  (frm_ready)
    );

    com_inspector u_com_inspector (
        .stream_clk_i (stream_clk),
        .stream_rst_i (stream_rst),
        .com_data_i   (com_inp_data_i),
        .com_valid_i  (com_inp_valid_i),
        .com_ready_o  (com_inp_ready_o),
        .dsp_data_o   (dsp_out_data_o),
        .dsp_valid_o  (dsp_out_valid_o),
        .dsp_ready_i  (dsp_out_ready_i),
        .host_data_o  (host_data),
        .host_valid_o (host_valid),
        .host_ready_i (host_ready)
    );

    packet_combiner u_packet_combiner (
        .stream_clk_i (stream_clk),
        .stream_rst_i (stream_rst),
        .frm_data_i   (frm_data),
        .frm_valid_i  (frm_valid),
        .frm_ready_o  (frm_ready),
        .host_data_i  (host_data),
        .host_valid_i (host_valid),
        .host_ready_o (host_ready),
        .out_data_o   (com_out_data_o),
        .out_valid_o  (com_out_valid_o),
        .out_ready_i  (com_out_ready_i)
    );

endmodule

// File: dv/packet_router_chk.sv
`timescale 1ns/1ps

module packet_router_chk (
    input logic                     stream_clk_i,
    input logic                     stream_rst_i,
    input router_pkg::stream_word_t com_out_data_i,
    input logic                     com_out_valid_i,
    input logic                     com_out_ready_i,
    input router_pkg::stream_word_t dsp_out_data_i,
    input logic                     dsp_out_valid_i,
    input logic                     dsp_out_ready_i,
    input logic                     dsp_inp_ready_i,
    input router_pkg::frm_state_e   frm_state_i
);
    import router_pkg::*;

    // running count of assertion failures
    int assert_fails = 0;

    // a stalled word stays on the output until it is taken
    a_com_out_hold: assert property (@(posedge stream_clk_i) disable iff (stream_rst_i)
        com_out_valid_i && !com_out_ready_i |=> com_out_valid_i && $stable(com_out_data_i))
        else begin
            $error("com_out word changed while stalled");
            assert_fails++;
        end

    a_dsp_out_hold: assert property (@(posedge stream_clk_i) disable iff (stream_rst_i)
        dsp_out_valid_i && !dsp_out_ready_i |=> dsp_out_valid_i && $stable(dsp_out_data_i))
        else begin
            $error("dsp_out word changed while stalled");
            assert_fails++;
        end

    // outputs come out of reset quiet
    a_quiet_after_reset: assert property (@(posedge stream_clk_i)
        $fell(stream_rst_i) |-> !com_out_valid_i && !dsp_out_valid_i)
        else begin
            $error("valid output high right after reset");
            assert_fails++;
        end

    a_dsp_inp_closed: assert property (@(posedge stream_clk_i) disable iff (stream_rst_i)
        (frm_state_i == frm_write_hdr || frm_state_i == frm_write_body) |-> !dsp_inp_ready_i)
        else begin
            $error("DSP input ready while the framer sends");
            assert_fails++;
        end

endmodule

bind packet_router packet_router_chk u_packet_router_chk (
    .stream_clk_i    (stream_clk),
    .stream_rst_i    (stream_rst),
    .com_out_data_i  (com_out_data_o),
    .com_out_valid_i (com_out_valid_o),
    .com_out_ready_i (com_out_ready_i),
    .dsp_out_data_i  (dsp_out_data_o),
    .dsp_out_valid_i (dsp_out_valid_o),
    .dsp_out_ready_i (dsp_out_ready_i),
    .dsp_inp_ready_i (dsp_inp_ready_o),
    .frm_state_i     (u_dsp_framer.state)
);

// File: dv/packet_router_tb.sv
`timescale 1ns/1ps
`include "router_consts.svh"

module packet_router_tb;
    import router_pkg::*;

    localparam int TIMEOUT   = 4000;
    localparam int BP_FULL   = 0;
    localparam int BP_RANDOM = 1;
    localparam int BP_STALL  = 2;

    logic         stream_clk;
    logic         stream_rst      = 1'b1;
    stream_word_t dsp_inp_data_i  = '0;
    logic         dsp_inp_valid_i = 1'b0;
    logic         dsp_inp_ready_o;
    stream_word_t com_inp_data_i  = '0;
    logic         com_inp_valid_i = 1'b0;
    logic         com_inp_ready_o;
    stream_word_t com_out_data_o;
    logic         com_out_valid_o;
    logic         com_out_ready_i = 1'b1;
    stream_word_t dsp_out_data_o;
    logic         dsp_out_valid_o;
    logic         dsp_out_ready_i = 1'b1;

    int seed    = 10;
    int bp_mode = BP_FULL;
    int errors  = 0;
    int checks  = 0;

    // packets to send, words expected and words seen on each output
    stream_word_t dsp_pkt [$];
    stream_word_t com_pkt [$];
    stream_word_t exp_com [$];
    stream_word_t exp_dsp [$];
    stream_word_t com_got [$];
    stream_word_t dsp_got [$];

    packet_router dut (
        .stream_clk      (stream_clk),
        .stream_rst      (stream_rst),
        .dsp_inp_data_i  (dsp_inp_data_i),
        .dsp_inp_valid_i (dsp_inp_valid_i),
        .dsp_inp_ready_o (dsp_inp_ready_o),
        .com_inp_data_i  (com_inp_data_i),
        .com_inp_valid_i (com_inp_valid_i),
        .com_inp_ready_o (com_inp_ready_o),
        .com_out_data_o  (com_out_data_o),
        .com_out_valid_o (com_out_valid_o),
        .com_out_ready_i (com_out_ready_i),
        .dsp_out_data_o  (dsp_out_data_o),
        .dsp_out_valid_o (dsp_out_valid_o),
        .dsp_out_ready_i (dsp_out_ready_i)
    );

    initial begin
        stream_clk = 1'b0;
        forever #10 stream_clk = ~stream_clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // output back-pressure and monitors
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge stream_clk) begin
        if (bp_mode == BP_RANDOM) begin
            com_out_ready_i <= (($random(seed) & 3) != 0);
            dsp_out_ready_i <= (($random(seed) & 3) != 0);
        end else begin
            com_out_ready_i <= (bp_mode == BP_FULL);
            dsp_out_ready_i <= (bp_mode == BP_FULL);
        end
    end

    always @(posedge stream_clk) begin
        if (!stream_rst && com_out_valid_o && com_out_ready_i) begin
            com_got.push_back(com_out_data_o);
        end
        if (!stream_rst && dsp_out_valid_o && dsp_out_ready_i) begin
            dsp_got.push_back(dsp_out_data_o);
        end
    end

    task automatic check_word(input string name, input stream_word_t exp_w,
                              input stream_word_t act_w);
        checks++;
        if (act_w !== exp_w) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp_w, act_w);
        end
    endtask

    task automatic check_count(input string name, input int exp_n, input int act_n);
        checks++;
        if (act_n != exp_n) begin
            errors++;
            $display("Fail %s: expected %0d words, actual %0d words", name, exp_n, act_n);
        end
    endtask

    task automatic apply_reset();
        stream_rst <= 1'b1;
        repeat (5) @(posedge stream_clk);
        stream_rst <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // packet builders with expected words from the router rules
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_dsp(input int n);
        stream_word_t w;
        stream_word_t hdr;
        int           i;
        dsp_pkt.delete();
        hdr      = '0;
        hdr.sof  = 1'b1;
        hdr.data = {`ROUTER_FRM_HDR_TAG, 16'(n * 4)};
        exp_com.push_back(hdr);
        for (i = 0; i < n; i++) begin
            w      = '0;
            w.data = $random(seed);
            w.sof  = (i == 0);
            w.eof  = (i == n - 1);
            dsp_pkt.push_back(w);
            // the header opens the frame so body words carry no sof
            w.sof = 1'b0;
            exp_com.push_back(w);
        end
    endtask

    task automatic build_com(input int n, input bit udp_hdr, input bit dsp_port);
        stream_word_t w;
        int           i;
        bit           to_dsp;
        com_pkt.delete();
        to_dsp = udp_hdr && dsp_port && (n >= `ROUTER_HDR_LINES);
        for (i = 0; i < n; i++) begin
            w      = '0;
            w.data = $random(seed);
            w.sof  = (i == 0);
            w.eof  = (i == n - 1);
            if (i == `ROUTER_ETHTYPE_IDX) begin
                w.data[15:0] = udp_hdr ? `ROUTER_ETHTYPE_IPV4 : 16'h86dd;
            end
            if (i == `ROUTER_PROTO_IDX) begin
                w.data[23:16] = `ROUTER_PROTO_UDP;
            end
            if (i == `ROUTER_PORT_IDX) begin
                w.data[15:0] = dsp_port ? `ROUTER_PORT_DSP : `ROUTER_PORT_DSP + 16'd1;
            end
            if (i == `ROUTER_DSP_OFFSET) begin
                w.data[31] = 1'b1;
            end
            com_pkt.push_back(w);
            if (!to_dsp) begin
                exp_com.push_back(w);
            end else if (i >= `ROUTER_DSP_OFFSET) begin
                w.sof = w.sof || (i == `ROUTER_DSP_OFFSET);
                exp_dsp.push_back(w);
            end
        end
    endtask

    task automatic send_dsp(input string name);
        int t;
        @(posedge stream_clk);
        foreach (dsp_pkt[i]) begin
            dsp_inp_data_i  <= dsp_pkt[i];
            dsp_inp_valid_i <= 1'b1;
            t = 0;
            do begin
                @(posedge stream_clk);
                t++;
            end while (!dsp_inp_ready_o && t < TIMEOUT);
            if (!dsp_inp_ready_o) begin
                errors++;
                $display("%s: timeout, DSP input never became ready", name);
                dsp_inp_valid_i <= 1'b0;
                return;
            end
        end
        dsp_inp_valid_i <= 1'b0;
    endtask

    task automatic send_com(input string name);
        int t;
        @(posedge stream_clk);
        foreach (com_pkt[i]) begin
            com_inp_data_i  <= com_pkt[i];
            com_inp_valid_i <= 1'b1;
            t = 0;
            do begin
                @(posedge stream_clk);
                t++;
            end while (!com_inp_ready_o && t < TIMEOUT);
            if (!com_inp_ready_o) begin
                errors++;
                $display("%s: timeout, communication input never became ready", name);
                com_inp_valid_i <= 1'b0;
                return;
            end
        end
        com_inp_valid_i <= 1'b0;
    endtask

    // waits for all expected words on one output, then compares in order
    task automatic expect_out(input string name, input bit from_dsp);
        int t;
        int n;
        int got;
        int i;
        n   = from_dsp ? exp_dsp.size() : exp_com.size();
        got = from_dsp ? dsp_got.size() : com_got.size();
        t   = 0;
        while (got < n && t < TIMEOUT) begin
            @(posedge stream_clk);
            t++;
            got = from_dsp ? dsp_got.size() : com_got.size();
        end
        if (got < n) begin
            errors++;
            $display("%s: timeout, only %0d of %0d output words arrived", name, got, n);
        end else begin
            check_count(name, n, got);
        end
        for (i = 0; i < n && i < got; i++) begin
            if (from_dsp) begin
                check_word(name, exp_dsp[i], dsp_got[i]);
            end else begin
                check_word(name, exp_com[i], com_got[i]);
            end
        end
        if (from_dsp) begin
            exp_dsp.delete();
            dsp_got.delete();
        end else begin
            exp_com.delete();
            com_got.delete();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic frame_dsp_packets();
        bp_mode = BP_FULL;
        build_dsp(5);
        send_dsp("dsp_framing");
        expect_out("dsp_framing", 1'b0);
        // largest packet the framer can hold
        build_dsp((1 << `ROUTER_BUF_SIZE) - 1);
        send_dsp("dsp_framing_max");
        expect_out("dsp_framing_max", 1'b0);
    endtask

    task automatic forward_udp_packet();
        bp_mode = BP_RANDOM;
        build_com(20, 1'b1, 1'b1);
        send_com("udp_packet");
        expect_out("udp_packet", 1'b1);
    endtask

    task automatic keep_long_packet();
        bp_mode = BP_RANDOM;
        build_com(24, 1'b1, 1'b0);
        send_com("long_host");
        expect_out("long_host", 1'b0);
    endtask

    task automatic keep_short_packet();
        bp_mode = BP_FULL;
        build_com(6, 1'b1, 1'b1);
        send_com("short_host");
        expect_out("short_host", 1'b0);
    endtask

    task automatic merge_traffic();
        int t;
        apply_reset();
        bp_mode = BP_STALL;
        // framer packet is expected ahead of the host packet
        build_dsp(8);
        build_com(14, 1'b0, 1'b0);
        fork
            send_dsp("combined");
            send_com("combined");
            begin
                t = 0;
                while ((dsp_inp_ready_o || com_inp_ready_o) && t < TIMEOUT) begin
                    @(posedge stream_clk);
                    t++;
                end
                if (dsp_inp_ready_o || com_inp_ready_o) begin
                    errors++;
                    $display("combined: timeout, both sources never held a packet");
                end
                bp_mode = BP_RANDOM;
            end
        join
        expect_out("combined", 1'b0);
    endtask

    initial begin
        apply_reset();
        frame_dsp_packets();
        forward_udp_packet();
        keep_long_packet();
        keep_short_packet();
        merge_traffic();
        check_count("leftover com_out", 0, com_got.size());
        check_count("leftover dsp_out", 0, dsp_got.size());
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut.u_packet_router_chk.assert_fails);
        if (errors == 0 && dut.u_packet_router_chk.assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: framer/dsp_framer.sv
`timescale 1ns/1ps
`include "router_consts.svh"

module dsp_framer (
    input  logic                     stream_clk_i,
    input  logic                     stream_rst_i,
    input  router_pkg::stream_word_t dsp_data_i,
    input  logic                     dsp_valid_i,
    output logic                     dsp_ready_o,
    output router_pkg::stream_word_t frm_data_o,
    output logic                     frm_valid_o,
    input  logic                     frm_ready_i
);
    import router_pkg::*;

    frm_state_e                  state;
    logic [`ROUTER_BUF_SIZE-1:0] addr;
    logic [`ROUTER_BUF_SIZE-1:0] addr_next;
    logic [`ROUTER_BUF_SIZE-1:0] count;
    logic [31:0]                 mem [0:(1 << `ROUTER_BUF_SIZE)-1];
    logic [31:0]                 rd_data;
    logic [15:0]                 byte_count;
    logic                        in_xfer;
    logic                        out_xfer;

    assign addr_next = addr + 1'b1;

    // input side open only while collecting a packet
    assign dsp_ready_o = (state == frm_wait_sof) || (state == frm_wait_eof);
    assign frm_valid_o = (state == frm_write_hdr) || (state == frm_write_body);

    assign in_xfer  = dsp_valid_i && dsp_ready_o;
    assign out_xfer = frm_valid_o && frm_ready_i;

    ////////////////////////////////////////////////////////////////////////////
    // packet store
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge stream_clk_i) begin
        if (in_xfer) begin
            mem[addr] <= dsp_data_i.data;
        end
    end

    // async read, word follows the address
    assign rd_data    = mem[addr];
    assign byte_count = 16'({count, 2'b00});

    // header word first, then the stored body
    always_comb begin
        frm_data_o = '0;
        if (state == frm_write_hdr) begin
            frm_data_o.sof  = 1'b1;
            frm_data_o.data = {`ROUTER_FRM_HDR_TAG, byte_count};
        end else begin
            frm_data_o.eof  = (addr_next == count);
            frm_data_o.data = rd_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // framer FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge stream_clk_i) begin
        if (stream_rst_i) begin
            state <= frm_wait_sof;
            addr  <= '0;
            count <= '0;
        end else begin
            case (state)
                frm_wait_sof: begin
                    // words ahead of a sof land at address 0 and get overwritten
                    if (in_xfer && dsp_data_i.sof) begin
                        if (dsp_data_i.eof) begin
                            count <= addr_next;
                            state <= frm_write_hdr;
                        end else begin
                            addr  <= addr_next;
                            state <= frm_wait_eof;
                        end
                    end
                end
                frm_wait_eof: begin
                    if (in_xfer) begin
                        if (dsp_data_i.eof) begin
                            count <= addr_next;
                            addr  <= '0;
                            state <= frm_write_hdr;
                        end else begin
                            addr <= addr_next;
                        end
                    end
                end
                frm_write_hdr: begin
                    if (out_xfer) begin
                        state <= frm_write_body;
                    end
                end
                frm_write_body: begin
                    if (out_xfer) begin
                        if (addr_next == count) begin
                            addr  <= '0;
                            state <= frm_wait_sof;
                        end else begin
                            addr <= addr_next;
                        end
                    end
                end
                default: state <= frm_wait_sof;
            endcase
        end
    end

endmodule

// File: inspector/com_inspector.sv
`timescale 1ns/1ps
`include "router_consts.svh"

module com_inspector (
    input  logic                     stream_clk_i,
    input  logic                     stream_rst_i,
    input  router_pkg::stream_word_t com_data_i,
    input  logic                     com_valid_i,
    output logic                     com_ready_o,
    output router_pkg::stream_word_t dsp_data_o,
    output logic                     dsp_valid_o,
    input  logic                     dsp_ready_i,
    output router_pkg::stream_word_t host_data_o,
    output logic                     host_valid_o,
    input  logic                     host_ready_i
);
    import router_pkg::*;

    insp_state_e  state;
    insp_dest_e   dest;
    logic [3:0]   cnt;
    logic [3:0]   cnt_next;
    logic         cnt_last;
    stream_word_t regs [0:`ROUTER_HDR_LINES-1];
    logic         capture;
    logic         is_dsp;
    stream_word_t out_word;
    logic         out_valid;
    logic         out_ready;
    logic         in_xfer;
    logic         out_xfer;

    assign cnt_next = cnt + 1'b1;
    assign cnt_last = (cnt == 4'(`ROUTER_HDR_LINES - 1));

    assign in_xfer  = com_valid_i && com_ready_o;
    assign out_xfer = out_valid && out_ready;

    ////////////////////////////////////////////////////////////////////////////
    // header registers and match
    ////////////////////////////////////////////////////////////////////////////

    assign capture = in_xfer &&
                     (((state == insp_read_first) && com_data_i.sof) ||
                      (state == insp_read_hdr));

    always_ff @(posedge stream_clk_i) begin
        if (capture) begin
            regs[cnt] <= com_data_i;
        end
    end

    // udp data packet to the dsp port, vrt line taken live as it arrives
    assign is_dsp = (regs[`ROUTER_ETHTYPE_IDX].data[15:0] == `ROUTER_ETHTYPE_IPV4) &&
                    (regs[`ROUTER_PROTO_IDX].data[23:16] == `ROUTER_PROTO_UDP) &&
                    (regs[`ROUTER_PORT_IDX].data[15:0] == `ROUTER_PORT_DSP) &&
                    (com_data_i.data != 32'h0);

    ////////////////////////////////////////////////////////////////////////////
    // output steering
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        out_word = com_data_i;
        if (state == insp_replay) begin
            out_word = regs[cnt];
            // dsp packets restart at the vrt line, so that line opens the packet
            if ((dest == dest_dsp) && (cnt == 4'(`ROUTER_DSP_OFFSET))) begin
                out_word.sof = 1'b1;
            end
        end
    end

    assign out_valid = (state == insp_replay) || ((state == insp_live) && com_valid_i);
    assign out_ready = (dest == dest_dsp) ? dsp_ready_i : host_ready_i;

    assign dsp_data_o   = out_word;
    assign host_data_o  = out_word;
    assign dsp_valid_o  = out_valid && (dest == dest_dsp);
    assign host_valid_o = out_valid && (dest == dest_host);

    always_comb begin
        case (state)
            insp_read_first: com_ready_o = 1'b1;
            insp_read_hdr:   com_ready_o = 1'b1;
            insp_live:       com_ready_o = out_ready;
            default:         com_ready_o = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // inspector FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge stream_clk_i) begin
        if (stream_rst_i) begin
            state <= insp_read_first;
            dest  <= dest_host;
            cnt   <= '0;
        end else begin
            case (state)
                insp_read_first: begin
                    if (in_xfer && com_data_i.sof) begin
                        if (com_data_i.eof) begin
                            // one line packet, nothing to inspect
                            dest  <= dest_host;
                            state <= insp_replay;
                        end else begin
                            cnt   <= cnt_next;
                            state <= insp_read_hdr;
                        end
                    end
                end
                insp_read_hdr: begin
                    if (in_xfer) begin
                        if (cnt_last && is_dsp) begin
                            dest  <= dest_dsp;
                            cnt   <= 4'(`ROUTER_DSP_OFFSET);
                            state <= insp_replay;
                        end else if (cnt_last || com_data_i.eof) begin
                            dest  <= dest_host;
                            cnt   <= '0;
                            state <= insp_replay;
                        end else begin
                            cnt <= cnt_next;
                        end
                    end
                end
                insp_replay: begin
                    if (out_xfer) begin
                        if (out_word.eof) begin
                            cnt   <= '0;
                            state <= insp_read_first;
                        end else if (cnt_last) begin
                            cnt   <= '0;
                            state <= insp_live;
                        end else begin
                            cnt <= cnt_next;
                        end
                    end
                end
                insp_live: begin
                    if (out_xfer && out_word.eof) begin
                        state <= insp_read_first;
                    end
                end
                default: state <= insp_read_first;
            endcase
        end
    end

endmodule

// File: packet_router.f
+incdir+common
common/router_pkg.sv
framer/dsp_framer.sv
inspector/com_inspector.sv
design/packet_combiner.sv
design/packet_router.sv
dv/packet_router_chk.sv
dv/packet_router_tb.sv
